// ==== compile.f ====
+incdir+common
common/trap_pkg.sv
src/trap_request.sv
sequencer/context_sequencer.sv
src/pc_redirect.sv
src/trap_unit.sv
tb/trap_unit_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the trap unit testbench with Verilator, run it and check the log.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	--top-module trap_unit_tb \
	-f compile.f

./obj_dir/Vtrap_unit_tb | tee sim.log

if ! grep -q "^TEST PASS$" sim.log; then
	echo "Simulation failed, see sim.log"
	exit 1
fi

exit 0

// ==== tb/trap_unit_tb.sv ====
`default_nettype none

`include "trap_macros.svh"

module trap_unit_tb import trap_pkg::*; ();

	localparam int KIND_SYSCALL = 0;
	localparam int KIND_TICK = 1;
	localparam int KIND_IRET = 2;

	typedef struct packed {
		uop_t               opcode;
		logic [`REG_AW-1:0] rt;
		logic [`REG_AW-1:0] ra;
		logic [`IMM_W-1:0]  imm;
		logic               store_pc;
	} uop_rec_t;

	logic               clock;
	logic               reset;
	logic               enable_system;
	logic               do_misc;
	misc_sel_t          select_misc;
	priv_mode_t         iret_mode;
	logic               systick;
	logic               uop_valid;
	uop_t               uop_opcode;
	logic [`REG_AW-1:0] uop_rt;
	logic [`REG_AW-1:0] uop_ra;
	logic [`IMM_W-1:0]  uop_imm;
	logic               store_pc;
	logic               load_pc;
	logic               halt_pc;
	logic               flush;
	logic               interrupt;
	logic [`XLEN-1:0]   interrupt_pc;
	logic               kernel_mode;

	uop_rec_t expected_q[$];
	int       seed = 4237;
	int       round;

	trap_unit DUT (
		.clock         (clock),
		.reset         (reset),
		.enable_system (enable_system),
		.do_misc       (do_misc),
		.select_misc   (select_misc),
		.iret_mode     (iret_mode),
		.systick       (systick),
		.uop_valid     (uop_valid),
		.uop_opcode    (uop_opcode),
		.uop_rt        (uop_rt),
		.uop_ra        (uop_ra),
		.uop_imm       (uop_imm),
		.store_pc      (store_pc),
		.load_pc       (load_pc),
		.halt_pc       (halt_pc),
		.flush         (flush),
		.interrupt     (interrupt),
		.interrupt_pc  (interrupt_pc),
		.kernel_mode   (kernel_mode)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	// Step 0 is the first micro-op of a save or a restore sequence.
	function automatic uop_rec_t expected_uop(input bit restore, input int step);
		uop_rec_t u;
		int       off;
		u.ra = `REG_SP;
		u.rt = '0;
		u.store_pc = 1'b0;
		if (!restore) begin
			u.opcode = (step == 8) ? UOP_ADDI : UOP_SWI;
			off = -(step + 1); // pc, lp, gp, fp, r3, r2, r1, r0 below sp.
			case (step)
				0: u.store_pc = 1'b1;
				1: u.rt = `REG_LP;
				2: u.rt = `REG_GP;
				3: u.rt = `REG_FP;
				4: u.rt = 5'd3;
				5: u.rt = 5'd2;
				6: u.rt = 5'd1;
				8: begin
					u.rt = `REG_SP;
					off = -`FRAME_BYTES;
				end
				default: ;
			endcase
		end else begin
			u.opcode = (step == 9) ? UOP_ADDI : UOP_LWI;
			off = (step == 0) ? 0 : step - 1; // Mode word first, then r0 to pc.
			case (step)
				2: u.rt = 5'd1;
				3: u.rt = 5'd2;
				4: u.rt = 5'd3;
				5: u.rt = `REG_FP;
				6: u.rt = `REG_GP;
				7: u.rt = `REG_LP;
				9: begin
					u.rt = `REG_SP;
					off = `FRAME_BYTES;
				end
				default: ;
			endcase
		end
		u.imm = off[`IMM_W-1:0];
		return u;
	endfunction

	task automatic check_value(input string what, input logic [31:0] got,
			input logic [31:0] want);
		if (got !== want) begin
			$display("ERROR at time %0t: %s is %h, expected %h", $time, what, got, want);
			$display("TEST FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout at time %0t: %s did not finish in time", $time, what);
		$display("TEST FAIL");
		$fatal(1, "timeout");
	endtask

	task automatic push_expected(input bit restore);
		for (int i = 0; i < (restore ? 10 : 9); i++) begin
			expected_q.push_back(expected_uop(restore, i));
		end
	endtask

	task automatic issue_trap(input int kind, input priv_mode_t mode);
		if (kind == KIND_TICK) begin
			systick <= 1'b1;
		end else begin
			do_misc <= 1'b1;
			select_misc <= (kind == KIND_IRET) ? MISC_IRET : MISC_SYSCALL;
			iret_mode <= mode;
		end
	endtask

	task automatic clear_strobes();
		do_misc <= 1'b0;
		select_misc <= MISC_NOP;
		systick <= 1'b0;
	endtask

	// Queue only shrinks while uop_valid is high, so the test below is stable.
	task automatic wait_idle(input int limit);
		int n;
		n = 0;
		while (halt_pc || interrupt || uop_valid || expected_q.size() != 0) begin
			@(negedge clock);
			n++;
			if (n > limit) report_timeout("trap sequence");
		end
	endtask

	task automatic check_reset_state();
		check_value("uop_valid", uop_valid, 1'b0);
		check_value("store_pc", store_pc, 1'b0);
		check_value("load_pc", load_pc, 1'b0);
		check_value("halt_pc", halt_pc, 1'b0);
		check_value("flush", flush, 1'b0);
		check_value("interrupt", interrupt, 1'b0);
		check_value("interrupt_pc", interrupt_pc, `VECTOR_RESET);
		check_value("kernel_mode", kernel_mode, 1'b1);
	endtask

	// Checks every cycle k after request edge 0 against the fixed trap timing.
	task automatic run_directed(input int kind, input priv_mode_t mode);
		bit               restore;
		int               first;
		int               count;
		int               halt_end;
		int               irq_at;
		int               k;
		logic [`XLEN-1:0] vec;
		restore = (kind == KIND_IRET);
		first = (kind == KIND_TICK) ? 2 : 1;
		count = restore ? 10 : 9;
		halt_end = restore ? 13 : first + 11;
		irq_at = restore ? -1 : first + 12;
		vec = (kind == KIND_TICK) ? `VECTOR_SYSTICK : `VECTOR_SYSCALL;
		push_expected(restore);
		@(negedge clock);
		issue_trap(kind, mode);
		for (k = 0; k <= 15; k++) begin
			@(negedge clock);
			if (k == 0) clear_strobes();
			check_value("uop_valid", uop_valid, k >= first && k < first + count);
			check_value("store_pc", store_pc, !restore && k == first);
			check_value("load_pc", load_pc, restore && k == 12);
			check_value("halt_pc", halt_pc, k >= 1 && k <= halt_end);
			check_value("interrupt", interrupt, k == irq_at);
			check_value("flush", flush, (k >= 1 && k <= halt_end) || k == irq_at);
			if (!restore && k >= 1) check_value("interrupt_pc", interrupt_pc, vec);
			if (!restore && k > irq_at) check_value("kernel_mode", kernel_mode, 1'b1);
			if (restore && k >= 2) check_value("kernel_mode", kernel_mode, mode == MODE_KERNEL);
		end
		check_value("micro-ops left", expected_q.size(), 0);
	endtask

	// Delay 0 raises the tick together with the system call.
	task automatic run_tick_pending(input int delay);
		push_expected(1'b0);
		push_expected(1'b0);
		@(negedge clock);
		issue_trap(KIND_SYSCALL, MODE_KERNEL);
		if (delay == 0) systick <= 1'b1;
		@(negedge clock);
		clear_strobes();
		if (delay > 0) begin
			repeat (delay - 1) @(negedge clock);
			systick <= 1'b1;
			@(negedge clock);
			systick <= 1'b0;
		end
		wait_idle(60);
		check_value("interrupt_pc", interrupt_pc, `VECTOR_SYSTICK);
		check_value("kernel_mode", kernel_mode, 1'b1);
	endtask

	task automatic run_stalled(input int kind, input priv_mode_t mode);
		int n;
		push_expected(kind == KIND_IRET);
		@(negedge clock);
		issue_trap(kind, mode);
		n = 0;
		do begin
			@(negedge clock);
			clear_strobes();
			enable_system <= ($random(seed) & 3) != 0; // Stall about one cycle in four.
			n++;
			if (n > 200) report_timeout("stalled micro-op stream");
		end while (expected_q.size() != 0 || uop_valid);
		enable_system <= 1'b1;
		wait_idle(40);
		if (kind == KIND_IRET) begin
			check_value("kernel_mode", kernel_mode, mode == MODE_KERNEL);
		end else begin
			check_value("interrupt_pc", interrupt_pc,
				(kind == KIND_TICK) ? `VECTOR_SYSTICK : `VECTOR_SYSCALL);
			check_value("kernel_mode", kernel_mode, 1'b1);
		end
	endtask

	// A micro-op is taken at the rising edge only when the system is enabled.
	always @(negedge clock) begin
		uop_rec_t want;
		if (reset === 1'b0 && enable_system === 1'b1 && uop_valid === 1'b1) begin
			if (expected_q.size() == 0) begin
				$display("Unexpected micro-op %s at time %0t", uop_opcode.name(), $time);
				$display("TEST FAIL");
				$fatal(1, "unexpected micro-op");
			end
			want = expected_q.pop_front();
			check_value("uop_opcode", uop_opcode, want.opcode);
			check_value("uop_rt", uop_rt, want.rt);
			check_value("uop_ra", uop_ra, want.ra);
			check_value("uop_imm", uop_imm, want.imm);
			check_value("store_pc", store_pc, want.store_pc);
			check_value("load_pc", load_pc, 1'b0);
		end
	end

	initial begin
		reset = 1'b1;
		enable_system = 1'b1;
		do_misc = 1'b0;
		select_misc = MISC_NOP;
		iret_mode = MODE_KERNEL;
		systick = 1'b0;
		repeat (10) @(negedge clock);
		reset <= 1'b0;
		@(negedge clock);
		check_reset_state();
		run_directed(KIND_IRET, MODE_USER);
		run_directed(KIND_SYSCALL, MODE_KERNEL);
		run_directed(KIND_IRET, MODE_USER);
		run_directed(KIND_TICK, MODE_KERNEL);
		run_directed(KIND_IRET, MODE_USER);
		run_directed(KIND_IRET, MODE_KERNEL);
		run_directed(KIND_IRET, MODE_USER);
		run_tick_pending(0);
		run_directed(KIND_IRET, MODE_USER);
		run_tick_pending(5);
		for (round = 0; round < 4; round++) begin
			repeat ($random(seed) & 7) @(negedge clock);
			run_stalled(KIND_IRET, MODE_USER);
			run_stalled(KIND_SYSCALL, MODE_KERNEL);
			run_stalled(KIND_IRET, MODE_USER);
			run_stalled(KIND_TICK, MODE_KERNEL);
		end
		@(negedge clock);
		if (expected_q.size() != 0 || halt_pc) begin
			$display("Run ended with micro-ops still expected or the PC still halted");
			$display("TEST FAIL");
			$fatal(1, "incomplete run");
		end else begin
			$display("TEST PASS");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== src/trap_unit.sv ====
`default_nettype none

`include "trap_macros.svh"

module trap_unit import trap_pkg::*; (
	input  logic               clock,
	input  logic               reset,
	input  logic               enable_system,
	input  logic               do_misc,
	input  misc_sel_t          select_misc,
	input  priv_mode_t         iret_mode,
	input  logic               systick,
	output logic               uop_valid,
	output uop_t               uop_opcode,
	output logic [`REG_AW-1:0] uop_rt,
	output logic [`REG_AW-1:0] uop_ra,
	output logic [`IMM_W-1:0]  uop_imm,
	output logic               store_pc,
	output logic               load_pc,
	output logic               halt_pc,
	output logic               flush,
	output logic               interrupt,
	output logic [`XLEN-1:0]   interrupt_pc,
	output logic               kernel_mode
);

	logic       seq_idle;
	logic       start_save;
	logic       save_is_tick;
	logic       start_restore;
	priv_mode_t restore_mode;
	logic       set_kernel;
	logic       set_user;
	logic       entry_done;
	logic       return_done;

	trap_request u_trap_request (
		.clock         (clock),
		.reset         (reset),
		.enable_system (enable_system),
		.do_misc       (do_misc),
		.select_misc   (select_misc),
		.iret_mode     (iret_mode),
		.systick       (systick),
		.seq_idle      (seq_idle),
		.start_save    (start_save),
		.save_is_tick  (save_is_tick),
		.start_restore (start_restore),
		.restore_mode  (restore_mode)
	);

	context_sequencer u_context_sequencer (
		.clock         (clock),
		.reset         (reset),
		.enable_system (enable_system),
		.start_save    (start_save),
		.save_is_tick  (save_is_tick),
		.start_restore (start_restore),
		.restore_mode  (restore_mode),
		.seq_idle      (seq_idle),
		.uop_valid     (uop_valid),
		.uop_opcode    (uop_opcode),
		.uop_rt        (uop_rt),
		.uop_ra        (uop_ra),
		.uop_imm       (uop_imm),
		.store_pc      (store_pc),
		.load_pc       (load_pc),
		.set_kernel    (set_kernel),
		.set_user      (set_user),
		.entry_done    (entry_done),
		.return_done   (return_done)
	);

	pc_redirect u_pc_redirect (
		.clock         (clock),
		.reset         (reset),
		.start_save    (start_save),
		.save_is_tick  (save_is_tick),
		.start_restore (start_restore),
		.set_kernel    (set_kernel),
		.set_user      (set_user),
		.entry_done    (entry_done),
		.return_done   (return_done),
		.halt_pc       (halt_pc),
		.flush         (flush),
		.interrupt     (interrupt),
		.interrupt_pc  (interrupt_pc),
		.kernel_mode   (kernel_mode)
	);

endmodule

`default_nettype wire

// ==== src/pc_redirect.sv ====
`default_nettype none

`include "trap_macros.svh"

module pc_redirect import trap_pkg::*; (
	input  logic             clock,
	input  logic             reset,
	input  logic             start_save,
	input  logic             save_is_tick,
	input  logic             start_restore,
	input  logic             set_kernel,
	input  logic             set_user,
	input  logic             entry_done,
	input  logic             return_done,
	output logic             halt_pc,
	output logic             flush,
	output logic             interrupt,
	output logic [`XLEN-1:0] interrupt_pc,
	output logic             kernel_mode
);

	priv_mode_t mode;

	always_ff @(posedge clock) begin
		if (reset) begin
			halt_pc <= 1'b0;
			interrupt <= 1'b0;
			interrupt_pc <= `VECTOR_RESET;
		end else begin
			interrupt <= entry_done; // One pulse as the frame is complete.
			if (start_save || start_restore) begin
				halt_pc <= 1'b1;
			end else if (entry_done || return_done) begin
				halt_pc <= 1'b0;
			end
			if (start_save) begin
				interrupt_pc <= save_is_tick ? `VECTOR_SYSTICK : `VECTOR_SYSCALL;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			mode <= MODE_KERNEL; // Boot in kernel mode.
		end else if (set_kernel) begin
			mode <= MODE_KERNEL;
		end else if (set_user) begin
			mode <= MODE_USER;
		end
	end

	assign flush = halt_pc || interrupt;
	assign kernel_mode = (mode == MODE_KERNEL);

endmodule

`default_nettype wire

// ==== sequencer/context_sequencer.sv ====
`default_nettype none

`include "trap_macros.svh"

module context_sequencer import trap_pkg::*; (
	input  logic               clock,
	input  logic               reset,
	input  logic               enable_system,
	input  logic               start_save,
	input  logic               save_is_tick,
	input  logic               start_restore,
	input  priv_mode_t         restore_mode,
	output logic               seq_idle,
	output logic               uop_valid,
	output uop_t               uop_opcode,
	output logic [`REG_AW-1:0] uop_rt,
	output logic [`REG_AW-1:0] uop_ra,
	output logic [`IMM_W-1:0]  uop_imm,
	output logic               store_pc,
	output logic               load_pc,
	output logic               set_kernel,
	output logic               set_user,
	output logic               entry_done,
	output logic               return_done
);

	seq_state_t state;
	seq_state_t state_next;

	// Signed word offset truncated to the immediate field.
	function automatic logic [`IMM_W-1:0] frame_off(input int words);
		frame_off = words[`IMM_W-1:0];
	endfunction

	always_comb begin
		state_next = seq_state_t'(state + 5'd1);
		case (state)
			IDLE: begin
				if (start_save) begin
					state_next = save_is_tick ? TICK_WAIT : SAVE_PC;
				end else if (start_restore) begin
					state_next = (restore_mode == MODE_KERNEL) ? LOAD_MODE_K : LOAD_MODE_U;
				end else begin
					state_next = IDLE;
				end
			end
			SAVE_W3: state_next = ENTER_KERNEL;
			ENTER_KERNEL: state_next = IDLE;
			LOAD_MODE_K, LOAD_MODE_U: state_next = LOAD_R0;
			LOAD_W3, SPARE: state_next = IDLE;
			default: ;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= IDLE;
		end else if (enable_system) begin
			state <= state_next;
		end
	end

	assign seq_idle = (state == IDLE);

	always_comb begin
		uop_opcode = UOP_NONE;
		uop_rt = '0;
		uop_imm = '0;
		store_pc = 1'b0;
		load_pc = 1'b0;
		set_kernel = 1'b0;
		set_user = 1'b0;
		entry_done = 1'b0;
		return_done = 1'b0;
		case (state)
			SAVE_PC: begin
				uop_opcode = UOP_SWI;
				uop_imm = frame_off(-1);
				store_pc = 1'b1; // Core supplies the PC as data.
			end
			SAVE_LP: begin
				uop_opcode = UOP_SWI;
				uop_rt = `REG_LP;
				uop_imm = frame_off(-2);
			end
			SAVE_GP: begin
				uop_opcode = UOP_SWI;
				uop_rt = `REG_GP;
				uop_imm = frame_off(-3);
			end
			SAVE_FP: begin
				uop_opcode = UOP_SWI;
				uop_rt = `REG_FP;
				uop_imm = frame_off(-4);
			end
			SAVE_R3: begin
				uop_opcode = UOP_SWI;
				uop_rt = 5'd3;
				uop_imm = frame_off(-5);
			end
			SAVE_R2: begin
				uop_opcode = UOP_SWI;
				uop_rt = 5'd2;
				uop_imm = frame_off(-6);
			end
			SAVE_R1: begin
				uop_opcode = UOP_SWI;
				uop_rt = 5'd1;
				uop_imm = frame_off(-7);
			end
			SAVE_R0: begin
				uop_opcode = UOP_SWI;
				uop_imm = frame_off(-`FRAME_WORDS);
			end
			SAVE_SP: begin
				uop_opcode = UOP_ADDI;
				uop_rt = `REG_SP;
				uop_imm = frame_off(-`FRAME_BYTES);
			end
			SAVE_W3: entry_done = 1'b1;
			ENTER_KERNEL: set_kernel = 1'b1;
			LOAD_MODE_K: begin
				uop_opcode = UOP_LWI;
				set_kernel = 1'b1;
			end
			LOAD_MODE_U: begin
				uop_opcode = UOP_LWI;
				set_user = 1'b1;
			end
			LOAD_R0: uop_opcode = UOP_LWI;
			LOAD_R1: begin
				uop_opcode = UOP_LWI;
				uop_rt = 5'd1;
				uop_imm = frame_off(1);
			end
			LOAD_R2: begin
				uop_opcode = UOP_LWI;
				uop_rt = 5'd2;
				uop_imm = frame_off(2);
			end
			LOAD_R3: begin
				uop_opcode = UOP_LWI;
				uop_rt = 5'd3;
				uop_imm = frame_off(3);
			end
			LOAD_FP: begin
				uop_opcode = UOP_LWI;
				uop_rt = `REG_FP;
				uop_imm = frame_off(4);
			end
			LOAD_GP: begin
				uop_opcode = UOP_LWI;
				uop_rt = `REG_GP;
				uop_imm = frame_off(5);
			end
			LOAD_LP: begin
				uop_opcode = UOP_LWI;
				uop_rt = `REG_LP;
				uop_imm = frame_off(6);
			end
			LOAD_PC: begin
				uop_opcode = UOP_LWI; // Result goes to the PC, no rt.
				uop_imm = frame_off(`FRAME_WORDS - 1);
			end
			LOAD_SP: begin
				uop_opcode = UOP_ADDI;
				uop_rt = `REG_SP;
				uop_imm = frame_off(`FRAME_BYTES);
			end
			LOAD_W2: load_pc = 1'b1;
			LOAD_W3: return_done = 1'b1;
			default: ;
		endcase
		uop_valid = (uop_opcode != UOP_NONE);
		uop_ra = uop_valid ? `REG_SP : '0; // Frame is always addressed off sp.
	end

	assert property (@(posedge clock) disable iff (reset)
		(state inside {IDLE, TICK_WAIT, SAVE_W1, SAVE_W2, SAVE_W3, ENTER_KERNEL,
			LOAD_W1, LOAD_W2, LOAD_W3}) |-> !uop_valid)
		else $error("micro-op issued in a wait state");

	assert property (@(posedge clock) disable iff (reset)
		!(store_pc && load_pc))
		else $error("store_pc and load_pc together");

endmodule

`default_nettype wire

// ==== src/trap_request.sv ====
`default_nettype none

module trap_request import trap_pkg::*; (
	input  logic       clock,
	input  logic       reset,
	input  logic       enable_system,
	input  logic       do_misc,
	input  misc_sel_t  select_misc,
	input  priv_mode_t iret_mode,
	input  logic       systick,
	input  logic       seq_idle,
	output logic       start_save,
	output logic       save_is_tick,
	output logic       start_restore,
	output priv_mode_t restore_mode
);

	logic tick_pending;
	logic tick_req;
	logic misc_save;
	logic misc_restore;
	logic can_start;
	logic tick_start;

	assign tick_req = systick || tick_pending;
	assign misc_save = do_misc && (select_misc == MISC_SYSCALL);
	assign misc_restore = do_misc && (select_misc == MISC_IRET);
	assign can_start = seq_idle && !start_save && !start_restore;
	// A misc trap in the same cycle beats the tick.
	assign tick_start = can_start && tick_req && !misc_save && !misc_restore;

	always_ff @(posedge clock) begin
		if (reset) begin
			start_save <= 1'b0;
			start_restore <= 1'b0;
			tick_pending <= 1'b0;
		end else if (enable_system) begin
			start_save <= (can_start && misc_save) || tick_start;
			start_restore <= can_start && misc_restore;
			tick_pending <= tick_req && !tick_start;
		end else begin
			tick_pending <= tick_pending || systick; // Strobes hold while stalled.
		end
	end

	always_ff @(posedge clock) begin
		if (enable_system && can_start) begin
			save_is_tick <= !misc_save;
			restore_mode <= iret_mode;
		end
	end

	// The core must not issue a trap while a sequence runs.
	assert property (@(posedge clock) disable iff (reset)
		do_misc |-> seq_idle)
		else $error("misc request while trap sequence busy");

endmodule

`default_nettype wire

// ==== common/trap_pkg.sv ====
`default_nettype none

package trap_pkg;

	// Order matters. The sequencer steps through consecutive codes.
	typedef enum logic [4:0] {
		IDLE = 5'd0,
		TICK_WAIT,
		SAVE_PC,
		SAVE_LP,
		SAVE_GP,
		SAVE_FP,
		SAVE_R3,
		SAVE_R2,
		SAVE_R1,
		SAVE_R0,
		SAVE_SP,
		SAVE_W1,
		SAVE_W2,
		SAVE_W3,
		ENTER_KERNEL,
		LOAD_MODE_K,
		LOAD_MODE_U,
		LOAD_R0,
		LOAD_R1,
		LOAD_R2,
		LOAD_R3,
		LOAD_FP,
		LOAD_GP,
		LOAD_LP,
		LOAD_PC,
		LOAD_SP,
		LOAD_W1,
		LOAD_W2,
		LOAD_W3,
		SPARE
	} seq_state_t;

	typedef enum logic [5:0] {
		UOP_NONE = 6'h00,
		UOP_ADDI = 6'h01, // Add immediate.
		UOP_LWI  = 6'h02, // Load word, base plus word offset.
		UOP_SWI  = 6'h03  // Store word, base plus word offset.
	} uop_t;

	typedef enum logic [1:0] {
		MISC_NOP     = 2'd0,
		MISC_SYSCALL = 2'd1,
		MISC_IRET    = 2'd2
	} misc_sel_t;

	typedef enum logic {
		MODE_USER   = 1'b0,
		MODE_KERNEL = 1'b1
	} priv_mode_t;

endpackage

`default_nettype wire

// ==== common/trap_macros.svh ====
`ifndef TRAP_MACROS_SVH
`define TRAP_MACROS_SVH

// Datapath widths.
`define XLEN   32
`define REG_AW 5
`define IMM_W  15

// Trap vectors.
`define VECTOR_RESET   32'h0000_0000
`define VECTOR_SYSCALL 32'h0000_0004
`define VECTOR_SYSTICK 32'h0000_0008

// Special registers.
`define REG_SP 5'd31
`define REG_LP 5'd30
`define REG_GP 5'd29
`define REG_FP 5'd28

// Saved frame below the stack pointer.
`define FRAME_WORDS 8
`define FRAME_BYTES 32

`endif
